// File: core_pkg.sv
package core_pkg;

   localparam int XLEN = 64;
   localparam int MEM_AW = 8;                // doubleword address bits.
   localparam int MEM_DEPTH = 1 << MEM_AW;
   localparam int SIZE_W = 4;                // access size in bytes.

   localparam logic [6:0] OPC_OPIMM = 7'b0010011;
   localparam logic [6:0] OPC_LOAD = 7'b0000011;
   localparam logic [6:0] OPC_STORE = 7'b0100011;

   // exu sequencer states
   localparam logic [2:0] ST_IDLE = 3'd0;
   localparam logic [2:0] ST_FETCH = 3'd1;
   localparam logic [2:0] ST_EXEC = 3'd2;
   localparam logic [2:0] ST_MEM = 3'd3;
   localparam logic [2:0] ST_WB = 3'd4;
   localparam logic [2:0] ST_HALT = 3'd5;

   typedef union packed {
      struct packed {
         logic [11:0] imm12;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         logic [6:0] opcode;
      } i_fmt;
      struct packed {
         logic [6:0] imm_hi;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] imm_lo;
         logic [6:0] opcode;
      } s_fmt;
   } insn_u;

endpackage

// File: idu.sv
module idu (
   input  core_pkg::insn_u              i_insn,
   input  logic                         i_valid,
   output logic                         o_rf_we,
   output logic [4:0]                   o_rd,
   output logic [4:0]                   o_rs1_addr,
   output logic [4:0]                   o_rs2_addr,
   output logic [11:0]                  o_imm12,
   output logic                         o_op_addi,
   output logic                         o_lsu_load,
   output logic                         o_lsu_store,
   output logic                         o_lsu_sigext,
   output logic [core_pkg::SIZE_W-1:0]  o_lsu_size,
   output logic                         o_wb_sel,
   output logic                         o_illegal,
   output logic                         o_valid
);

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic       is_opimm;
   logic       is_load;
   logic       is_store;

   assign opcode = i_insn.i_fmt.opcode;
   assign funct3 = i_insn.i_fmt.funct3;

   assign is_opimm = (opcode == core_pkg::OPC_OPIMM);
   assign is_load = (opcode == core_pkg::OPC_LOAD);
   assign is_store = (opcode == core_pkg::OPC_STORE);

   assign o_op_addi = is_opimm & (funct3 == 3'b000);
   assign o_lsu_load = is_load & (funct3 != 3'b111);    // lb..ld, lbu, lhu, lwu.
   assign o_lsu_store = is_store & ~funct3[2];          // sb, sh, sw, sd.

   // funct3[1:0] is the log2 size for every load and store form
   always_comb begin
      case (funct3[1:0])
         2'd0: o_lsu_size = 4'd1;
         2'd1: o_lsu_size = 4'd2;
         2'd2: o_lsu_size = 4'd4;
         default: o_lsu_size = 4'd8;
      endcase
   end

   assign o_lsu_sigext = o_lsu_load & ~funct3[2];

   assign o_imm12 = is_store ? {i_insn.s_fmt.imm_hi, i_insn.s_fmt.imm_lo}
                             : i_insn.i_fmt.imm12;

   assign o_rf_we = o_op_addi | o_lsu_load;
   assign o_rd = i_insn.i_fmt.rd;
   assign o_rs1_addr = i_insn.i_fmt.rs1;
   assign o_rs2_addr = o_lsu_store ? i_insn.s_fmt.rs2 : 5'd0;
   assign o_wb_sel = o_lsu_load;                        // 1 = lsu result.

   assign o_illegal = i_valid & ~(o_op_addi | o_lsu_load | o_lsu_store);
   assign o_valid = i_valid;

endmodule

// File: ifu.sv
module ifu (
   input  logic                          i_clk,
   input  logic                          i_rst_n,
   input  logic                          i_run,
   input  logic                          i_fetch,
   input  logic                          i_gnt,
   input  logic [core_pkg::XLEN-1:0]     i_rdata,
   output logic                          o_req,
   output logic [core_pkg::MEM_AW-1:0]   o_addr,
   output core_pkg::insn_u               o_insn,
   output logic                          o_insn_valid
);

   logic [core_pkg::MEM_AW+2:0] pc;
   logic                        pend_q;
   logic                        rd_q;

   assign o_req = i_fetch | pend_q;
   assign o_addr = pc[core_pkg::MEM_AW+2:3];

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc <= '0;
         pend_q <= 1'b0;
         rd_q <= 1'b0;
         o_insn_valid <= 1'b0;
      end else begin
         pend_q <= o_req & ~i_gnt & i_run;              // held until granted.
         rd_q <= o_req & i_gnt;
         o_insn_valid <= rd_q;
         if (!i_run) begin
            pc <= '0;
         end else if (o_insn_valid) begin
            pc <= pc + 4;
         end
      end
   end

   // pc[2] picks the half of the doubleword.
   always_ff @(posedge i_clk) begin
      if (rd_q) begin
         o_insn <= pc[2] ? i_rdata[63:32] : i_rdata[31:0];
      end
   end

endmodule

// File: regfile.sv
module regfile (
   input  logic                       i_clk,
   input  logic                       i_rst_n,
   input  logic [4:0]                 i_rs1_addr,
   input  logic [4:0]                 i_rs2_addr,
   input  logic                       i_we,
   input  logic [4:0]                 i_rd,
   input  logic [core_pkg::XLEN-1:0]  i_wdata,
   output logic [core_pkg::XLEN-1:0]  o_rs1_data,
   output logic [core_pkg::XLEN-1:0]  o_rs2_data
);

   logic [core_pkg::XLEN-1:0] regs [32];

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we && i_rd != 5'd0) begin     // x0 stays zero.
         regs[i_rd] <= i_wdata;
      end
   end

   assign o_rs1_data = regs[i_rs1_addr];
   assign o_rs2_data = regs[i_rs2_addr];

endmodule

// File: exu.sv
module exu (
   input  logic                       i_clk,
   input  logic                       i_rst_n,
   input  logic                       i_run,
   input  logic                       i_insn_valid,
   input  logic                       i_rf_we,
   input  logic [11:0]                i_imm12,
   input  logic                       i_op_addi,
   input  logic                       i_lsu_load,
   input  logic                       i_lsu_store,
   input  logic                       i_wb_sel,
   input  logic                       i_illegal,
   input  logic [core_pkg::XLEN-1:0]  i_rs1_data,
   input  logic [core_pkg::XLEN-1:0]  i_rs2_data,
   input  logic                       i_lsu_done,
   input  logic [core_pkg::XLEN-1:0]  i_load_data,
   output logic                       o_fetch,
   output logic                       o_lsu_start,
   output logic [core_pkg::XLEN-1:0]  o_addr_sum,
   output logic [core_pkg::XLEN-1:0]  o_store_data,
   output logic                       o_rf_we,
   output logic [core_pkg::XLEN-1:0]  o_rf_wdata,
   output logic                       o_halt
);

   logic [2:0] state_q;
   logic [2:0] state_d;
   logic       bad_q;

   always_comb begin
      state_d = state_q;
      case (state_q)
         core_pkg::ST_IDLE: begin
            if (i_run) state_d = core_pkg::ST_FETCH;
         end
         core_pkg::ST_FETCH: begin
            if (i_insn_valid) state_d = core_pkg::ST_EXEC;
         end
         core_pkg::ST_EXEC: begin
            if (bad_q) begin
               state_d = core_pkg::ST_HALT;
            end else if (i_op_addi) begin
               state_d = core_pkg::ST_WB;
            end else begin
               state_d = core_pkg::ST_MEM;
            end
         end
         core_pkg::ST_MEM: begin
            if (i_lsu_done) state_d = core_pkg::ST_WB;
         end
         core_pkg::ST_WB: state_d = core_pkg::ST_FETCH;
         core_pkg::ST_HALT: state_d = core_pkg::ST_HALT;  // until run falls.
         default: state_d = core_pkg::ST_IDLE;
      endcase
      if (!i_run) state_d = core_pkg::ST_IDLE;
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state_q <= core_pkg::ST_IDLE;
         bad_q <= 1'b0;
      end else begin
         state_q <= state_d;
         if (i_insn_valid) bad_q <= i_illegal;
      end
   end

   // next fetch is issued from idle or from writeback.
   assign o_fetch = i_run & (state_q == core_pkg::ST_IDLE | state_q == core_pkg::ST_WB);
   assign o_lsu_start = (state_q == core_pkg::ST_EXEC) & (i_lsu_load | i_lsu_store);

   // shared adder for addi and the memory address
   assign o_addr_sum = i_rs1_data + {{52{i_imm12[11]}}, i_imm12};
   assign o_store_data = i_rs2_data;

   assign o_rf_we = (state_q == core_pkg::ST_WB) & i_rf_we;
   assign o_rf_wdata = i_wb_sel ? i_load_data : o_addr_sum;
   assign o_halt = (state_q == core_pkg::ST_HALT);

endmodule

// File: lsu.sv
module lsu (
   input  logic                          i_clk,
   input  logic                          i_rst_n,
   input  logic                          i_start,
   input  logic                          i_load,
   input  logic                          i_store,
   input  logic [core_pkg::SIZE_W-1:0]   i_size,
   input  logic                          i_sigext,
   input  logic [core_pkg::XLEN-1:0]     i_addr,
   input  logic [core_pkg::XLEN-1:0]     i_wdata,
   input  logic                          i_gnt,
   input  logic [core_pkg::XLEN-1:0]     i_rdata,
   output logic                          o_req,
   output logic                          o_we,
   output logic [7:0]                    o_be,
   output logic [core_pkg::MEM_AW-1:0]   o_mem_addr,
   output logic [core_pkg::XLEN-1:0]     o_mem_wdata,
   output logic                          o_done,
   output logic [core_pkg::XLEN-1:0]     o_load_data
);

   logic [2:0]                  size_m;
   logic [2:0]                  off;
   logic [7:0]                  be_base;
   logic [2:0]                  off_q;
   logic [core_pkg::SIZE_W-1:0] size_q;
   logic                        sigext_q;
   logic                        wr_done_q;
   logic                        rd_done_q;
   logic [core_pkg::XLEN-1:0]   shifted;
   logic [core_pkg::XLEN-1:0]   ext;

   assign size_m = i_size[2:0] - 3'd1;       // 8 wraps to 7.
   assign off = i_addr[2:0] & ~size_m;       // drop bits below the size.

   always_comb begin
      case (size_m)
         3'd0: be_base = 8'h01;
         3'd1: be_base = 8'h03;
         3'd3: be_base = 8'h0f;
         default: be_base = 8'hff;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_req <= 1'b0;
         wr_done_q <= 1'b0;
         rd_done_q <= 1'b0;
      end else begin
         o_req <= (i_start & (i_load | i_store)) | (o_req & ~i_gnt);
         wr_done_q <= o_req & i_gnt & o_we;
         rd_done_q <= o_req & i_gnt & ~o_we;    // read data is on the bus now.
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_start) begin
         o_we <= i_store;
         o_be <= be_base << off;
         o_mem_addr <= i_addr[core_pkg::MEM_AW+2:3];
         o_mem_wdata <= i_wdata << {off, 3'b000};
         off_q <= off;
         size_q <= i_size;
         sigext_q <= i_sigext;
      end
      if (rd_done_q) o_load_data <= ext;
   end

   assign shifted = i_rdata >> {off_q, 3'b000};

   always_comb begin
      case (size_q)
         4'd1: ext = {{56{sigext_q & shifted[7]}}, shifted[7:0]};
         4'd2: ext = {{48{sigext_q & shifted[15]}}, shifted[15:0]};
         4'd4: ext = {{32{sigext_q & shifted[31]}}, shifted[31:0]};
         default: ext = shifted;
      endcase
   end

   assign o_done = wr_done_q | rd_done_q;

endmodule

// File: mem_arb.sv
module mem_arb (
   input  logic                          i_host_req,
   input  logic                          i_host_we,
   input  logic [core_pkg::MEM_AW-1:0]   i_host_addr,
   input  logic [core_pkg::XLEN-1:0]     i_host_wdata,
   input  logic                          i_lsu_req,
   input  logic                          i_lsu_we,
   input  logic [7:0]                    i_lsu_be,
   input  logic [core_pkg::MEM_AW-1:0]   i_lsu_addr,
   input  logic [core_pkg::XLEN-1:0]     i_lsu_wdata,
   input  logic                          i_ifu_req,
   input  logic [core_pkg::MEM_AW-1:0]   i_ifu_addr,
   input  logic [core_pkg::XLEN-1:0]     i_mem_rdata,
   output logic                          o_host_gnt,
   output logic                          o_lsu_gnt,
   output logic                          o_ifu_gnt,
   output logic                          o_mem_en,
   output logic                          o_mem_we,
   output logic [7:0]                    o_mem_be,
   output logic [core_pkg::MEM_AW-1:0]   o_mem_addr,
   output logic [core_pkg::XLEN-1:0]     o_mem_wdata,
   output logic [core_pkg::XLEN-1:0]     o_rdata
);

   // host first, then lsu, then ifu.
   assign o_host_gnt = i_host_req;
   assign o_lsu_gnt = i_lsu_req & ~i_host_req;
   assign o_ifu_gnt = i_ifu_req & ~i_host_req & ~i_lsu_req;
   assign o_mem_en = i_host_req | i_lsu_req | i_ifu_req;

   always_comb begin
      if (i_host_req) begin
         o_mem_we = i_host_we;
         o_mem_be = 8'hff;                   // host writes whole words.
         o_mem_addr = i_host_addr;
         o_mem_wdata = i_host_wdata;
      end else if (i_lsu_req) begin
         o_mem_we = i_lsu_we;
         o_mem_be = i_lsu_be;
         o_mem_addr = i_lsu_addr;
         o_mem_wdata = i_lsu_wdata;
      end else begin
         o_mem_we = 1'b0;
         o_mem_be = 8'h00;
         o_mem_addr = i_ifu_addr;
         o_mem_wdata = '0;
      end
   end

   assign o_rdata = i_mem_rdata;

endmodule

// File: unified_mem.sv
module unified_mem (
   input  logic                          i_clk,
   input  logic                          i_en,
   input  logic                          i_we,
   input  logic [7:0]                    i_be,
   input  logic [core_pkg::MEM_AW-1:0]   i_addr,
   input  logic [core_pkg::XLEN-1:0]     i_wdata,
   output logic [core_pkg::XLEN-1:0]     o_rdata
);

   logic [core_pkg::XLEN-1:0] mem [core_pkg::MEM_DEPTH];

   always_ff @(posedge i_clk) begin
      if (i_en) begin
         if (i_we) begin
            for (int b = 0; b < 8; b++) begin
               if (i_be[b]) begin
                  mem[i_addr][b*8 +: 8] <= i_wdata[b*8 +: 8];
               end
            end
         end else begin
            o_rdata <= mem[i_addr];          // one cycle read.
         end
      end
   end

endmodule

// File: core_top.sv
module core_top (
   input  logic                          i_clk,
   input  logic                          i_rst_n,
   input  logic                          i_run,
   input  logic                          i_host_req,
   input  logic                          i_host_we,
   input  logic [core_pkg::MEM_AW-1:0]   i_host_addr,
   input  logic [core_pkg::XLEN-1:0]     i_host_wdata,
   output logic                          o_host_gnt,
   output logic [core_pkg::XLEN-1:0]     o_host_rdata,
   output logic                          o_halt
);

   logic                        ifu_req, ifu_gnt, fetch, insn_valid;
   logic [core_pkg::MEM_AW-1:0] ifu_addr;
   core_pkg::insn_u             insn;

   logic                        dec_rf_we, op_addi, lsu_load, lsu_store, lsu_sigext;
   logic                        wb_sel, illegal, dec_valid;
   logic [4:0]                  rd, rs1_addr, rs2_addr;
   logic [11:0]                 imm12;
   logic [core_pkg::SIZE_W-1:0] lsu_size;

   logic [core_pkg::XLEN-1:0]   rs1_data, rs2_data, addr_sum, store_data;
   logic [core_pkg::XLEN-1:0]   rf_wdata, load_data;
   logic                        rf_we, lsu_start, lsu_done;

   logic                        lsu_req, lsu_gnt, lsu_we;
   logic [7:0]                  lsu_be;
   logic [core_pkg::MEM_AW-1:0] lsu_addr;
   logic [core_pkg::XLEN-1:0]   lsu_wdata;

   logic                        mem_en, mem_we;
   logic [7:0]                  mem_be;
   logic [core_pkg::MEM_AW-1:0] mem_addr;
   logic [core_pkg::XLEN-1:0]   mem_wdata, mem_rdata, rdata;

   assign o_host_rdata = rdata;

   ifu u_ifu (
      .i_clk(i_clk), .i_rst_n(i_rst_n), .i_run(i_run), .i_fetch(fetch),
      .i_gnt(ifu_gnt), .i_rdata(rdata), .o_req(ifu_req), .o_addr(ifu_addr),
      .o_insn(insn), .o_insn_valid(insn_valid)
   );

   idu u_idu (
      .i_insn(insn), .i_valid(insn_valid), .o_rf_we(dec_rf_we), .o_rd(rd),
      .o_rs1_addr(rs1_addr), .o_rs2_addr(rs2_addr), .o_imm12(imm12),
      .o_op_addi(op_addi), .o_lsu_load(lsu_load), .o_lsu_store(lsu_store),
      .o_lsu_sigext(lsu_sigext), .o_lsu_size(lsu_size), .o_wb_sel(wb_sel),
      .o_illegal(illegal), .o_valid(dec_valid)
   );

   regfile u_regfile (
      .i_clk(i_clk), .i_rst_n(i_rst_n), .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr),
      .i_we(rf_we), .i_rd(rd), .i_wdata(rf_wdata),
      .o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
   );

   exu u_exu (
      .i_clk(i_clk), .i_rst_n(i_rst_n), .i_run(i_run), .i_insn_valid(dec_valid),
      .i_rf_we(dec_rf_we), .i_imm12(imm12), .i_op_addi(op_addi),
      .i_lsu_load(lsu_load), .i_lsu_store(lsu_store), .i_wb_sel(wb_sel),
      .i_illegal(illegal), .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
      .i_lsu_done(lsu_done), .i_load_data(load_data), .o_fetch(fetch),
      .o_lsu_start(lsu_start), .o_addr_sum(addr_sum), .o_store_data(store_data),
      .o_rf_we(rf_we), .o_rf_wdata(rf_wdata), .o_halt(o_halt)
   );

   lsu u_lsu (
      .i_clk(i_clk), .i_rst_n(i_rst_n), .i_start(lsu_start), .i_load(lsu_load),
      .i_store(lsu_store), .i_size(lsu_size), .i_sigext(lsu_sigext),
      .i_addr(addr_sum), .i_wdata(store_data), .i_gnt(lsu_gnt), .i_rdata(rdata),
      .o_req(lsu_req), .o_we(lsu_we), .o_be(lsu_be), .o_mem_addr(lsu_addr),
      .o_mem_wdata(lsu_wdata), .o_done(lsu_done), .o_load_data(load_data)
   );

   mem_arb u_mem_arb (
      .i_host_req(i_host_req), .i_host_we(i_host_we), .i_host_addr(i_host_addr),
      .i_host_wdata(i_host_wdata), .i_lsu_req(lsu_req), .i_lsu_we(lsu_we),
      .i_lsu_be(lsu_be), .i_lsu_addr(lsu_addr), .i_lsu_wdata(lsu_wdata),
      .i_ifu_req(ifu_req), .i_ifu_addr(ifu_addr), .i_mem_rdata(mem_rdata),
      .o_host_gnt(o_host_gnt), .o_lsu_gnt(lsu_gnt), .o_ifu_gnt(ifu_gnt),
      .o_mem_en(mem_en), .o_mem_we(mem_we), .o_mem_be(mem_be),
      .o_mem_addr(mem_addr), .o_mem_wdata(mem_wdata), .o_rdata(rdata)
   );

   unified_mem u_unified_mem (
      .i_clk(i_clk), .i_en(mem_en), .i_we(mem_we), .i_be(mem_be),
      .i_addr(mem_addr), .i_wdata(mem_wdata), .o_rdata(mem_rdata)
   );

endmodule

// File: tb_clk.sv
module tb_clk #(
   parameter int PERIOD = 40
) (
   output logic o_clk
);
   timeunit 1ns;
   timeprecision 1ps;

   initial o_clk = 1'b0;

   always #(PERIOD / 2) o_clk = ~o_clk;

endmodule

// File: tb_top.sv
module tb_top;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int ROWS = 19;
   localparam int SLOTS = 16;                   // instruction words per program.
   localparam int DW = 8;                       // data words per row.
   localparam int DBASE = 16;                   // first data word at byte 128.

   logic                        clk, rst_n, run, host_req, host_we, host_gnt, halt;
   logic [core_pkg::MEM_AW-1:0] host_addr;
   logic [core_pkg::XLEN-1:0]   host_wdata, host_rdata;

   core_pkg::insn_u             prog [ROWS][SLOTS];
   logic [core_pkg::XLEN-1:0]   pre [ROWS][DW];
   logic [core_pkg::XLEN-1:0]   expect_w [ROWS][DW];
   int                          n_insn [ROWS];
   int                          limit, cycles, checks, errors;

   tb_clk u_tb_clk (.o_clk(clk));

   core_top u_core_top (
      .i_clk(clk), .i_rst_n(rst_n), .i_run(run), .i_host_req(host_req),
      .i_host_we(host_we), .i_host_addr(host_addr), .i_host_wdata(host_wdata),
      .o_host_gnt(host_gnt), .o_host_rdata(host_rdata), .o_halt(halt)
   );

   function automatic core_pkg::insn_u i_type(input logic [6:0] opc, input logic [2:0] f3,
         input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
      core_pkg::insn_u w;
      w.i_fmt.opcode = opc;
      w.i_fmt.funct3 = f3;
      w.i_fmt.rd = rd;
      w.i_fmt.rs1 = rs1;
      w.i_fmt.imm12 = imm;
      return w;
   endfunction

   function automatic core_pkg::insn_u s_type(input logic [2:0] f3, input logic [4:0] rs2,
         input logic [4:0] rs1, input logic [11:0] imm);
      core_pkg::insn_u w;
      w.s_fmt.opcode = core_pkg::OPC_STORE;
      w.s_fmt.funct3 = f3;
      w.s_fmt.rs2 = rs2;
      w.s_fmt.rs1 = rs1;
      w.s_fmt.imm_hi = imm[11:5];                // split immediate.
      w.s_fmt.imm_lo = imm[4:0];
      return w;
   endfunction

   // little-endian bytes off..off+n-1, then sign or zero fill
   function automatic logic [core_pkg::XLEN-1:0] load_ref(input logic [core_pkg::XLEN-1:0] d,
         input int off, input int n, input logic sgn);
      logic [core_pkg::XLEN-1:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r[i * 8 +: 8] = d[(off + i) * 8 +: 8];
      end
      for (int i = n; i < 8; i++) begin
         r[i * 8 +: 8] = {8{sgn & r[n * 8 - 1]}};
      end
      return r;
   endfunction

   function automatic logic [core_pkg::XLEN-1:0] store_ref(input logic [core_pkg::XLEN-1:0] d,
         input int off, input int n, input logic [core_pkg::XLEN-1:0] v);
      logic [core_pkg::XLEN-1:0] r;
      r = d;
      for (int i = 0; i < n; i++) begin
         r[(off + i) * 8 +: 8] = v[i * 8 +: 8];
      end
      return r;
   endfunction

   task automatic emit(input int r, input core_pkg::insn_u w);
      prog[r][n_insn[r]] = w;
      n_insn[r]++;
   endtask

   task automatic build_table();
      logic [11:0]               a, b;
      logic [core_pkg::XLEN-1:0] v;
      int                        n, off, r;
      for (int i = 0; i < ROWS; i++) begin
         n_insn[i] = 0;
         for (int j = 0; j < SLOTS; j++) begin
            prog[i][j] = '0;                     // zero word ends the program.
         end
         for (int j = 0; j < DW; j++) begin
            pre[i][j] = {$urandom, $urandom};
            expect_w[i][j] = pre[i][j];
         end
      end
      // row 0 chains addi and then writes x0.
      a = {1'b0, 11'($urandom)};
      b = {1'b1, 11'($urandom)};
      emit(0, i_type(core_pkg::OPC_OPIMM, 3'd0, 5'd1, 5'd0, 12'd128));
      emit(0, i_type(core_pkg::OPC_OPIMM, 3'd0, 5'd2, 5'd0, a));
      emit(0, i_type(core_pkg::OPC_OPIMM, 3'd0, 5'd3, 5'd2, b));
      emit(0, i_type(core_pkg::OPC_OPIMM, 3'd0, 5'd0, 5'd2, 12'd5));
      for (int j = 0; j < 3; j++) begin
         emit(0, s_type(3'd3, 5'(j == 2 ? 0 : j + 2), 5'd1, 12'(8 * j)));
      end
      expect_w[0][0] = 64'(a);                               // a is positive.
      expect_w[0][1] = 64'(a) + 64'(b) - 64'd4096;           // b is negative.
      expect_w[0][2] = '0;
      // rows 1..8 run every load form at byte offset k
      for (int k = 0; k < 8; k++) begin
         r = 1 + k;
         pre[r][0] = ((k & 2) != 0) ? pre[r][0] & 64'h7f7f_7f7f_7f7f_7f7f
                                    : pre[r][0] | 64'h8080_8080_8080_8080;
         expect_w[r][0] = pre[r][0];
         emit(r, i_type(core_pkg::OPC_OPIMM, 3'd0, 5'd1, 5'd0, 12'd128));
         for (int j = 0; j < 7; j++) begin
            n = 1 << (j / 2);
            off = k & ~(n - 1);
            emit(r, i_type(core_pkg::OPC_LOAD, 3'((j % 2) * 4 + j / 2), 5'(2 + j), 5'd1,
                           12'(off)));
            expect_w[r][j + 1] = load_ref(pre[r][0], off, n, (j % 2) == 0);
         end
         for (int j = 0; j < 7; j++) begin
            emit(r, s_type(3'd3, 5'(2 + j), 5'd1, 12'(8 * j + 8)));
         end
      end
      // rows 9..16 store bytes, halves and words at offset k into preloaded words
      for (int k = 0; k < 8; k++) begin
         r = 9 + k;
         v = pre[r][3];
         emit(r, i_type(core_pkg::OPC_OPIMM, 3'd0, 5'd1, 5'd0, 12'd128));
         emit(r, i_type(core_pkg::OPC_LOAD, 3'd3, 5'd2, 5'd1, 12'd24));
         for (int j = 0; j < 3; j++) begin
            n = 1 << j;
            off = k & ~(n - 1);
            emit(r, s_type(3'(j), 5'd2, 5'd1, 12'(8 * j + off)));
            expect_w[r][j] = store_ref(pre[r][j], off, n, v);
         end
         emit(r, s_type(3'd3, 5'd2, 5'd1, 12'd32));
         expect_w[r][4] = v;
      end
      // row 17 uses negative offsets split over imm_hi and imm_lo.
      emit(17, i_type(core_pkg::OPC_OPIMM, 3'd0, 5'd1, 5'd0, 12'd2000));
      emit(17, i_type(core_pkg::OPC_OPIMM, 3'd0, 5'd2, 5'd0, 12'hedc));  // -292.
      emit(17, i_type(core_pkg::OPC_OPIMM, 3'd0, 5'd3, 5'd0, 12'h123));
      emit(17, s_type(3'd3, 5'd2, 5'd1, 12'h8b0));                       // byte 128.
      emit(17, i_type(core_pkg::OPC_OPIMM, 3'd0, 5'd4, 5'd1, 12'hc18));  // x4 = 1000.
      emit(17, s_type(3'd3, 5'd3, 5'd4, 12'hca0));                       // byte 136.
      emit(17, s_type(3'd2, 5'd3, 5'd4, 12'hcac));                       // byte 148.
      emit(17, i_type(core_pkg::OPC_LOAD, 3'd3, 5'd5, 5'd1, 12'h8b8));   // byte 136.
      emit(17, s_type(3'd3, 5'd5, 5'd1, 12'h8c8));                       // byte 152.
      expect_w[17][0] = 64'hffff_ffff_ffff_fedc;
      expect_w[17][1] = 64'h123;
      expect_w[17][2] = {32'h0000_0123, pre[17][2][31:0]};
      expect_w[17][3] = 64'h123;
      // row 18 halts on andi, so the last store never happens
      emit(18, i_type(core_pkg::OPC_OPIMM, 3'd0, 5'd1, 5'd0, 12'd128));
      emit(18, i_type(core_pkg::OPC_OPIMM, 3'd0, 5'd2, 5'd0, 12'd77));
      emit(18, s_type(3'd3, 5'd2, 5'd1, 12'd0));
      emit(18, i_type(core_pkg::OPC_OPIMM, 3'd7, 5'd2, 5'd2, 12'd1));
      emit(18, s_type(3'd3, 5'd2, 5'd1, 12'd8));
      expect_w[18][0] = 64'd77;
      limit = 40;
      for (int i = 0; i < ROWS; i++) begin
         limit += 2 * (6 * (n_insn[i] + 1) + 3 * (SLOTS / 2 + 2 * DW) + 8);
      end
   endtask

   task automatic host_write(input int a, input logic [core_pkg::XLEN-1:0] d);
      @(posedge clk);
      host_req <= 1'b1;
      host_we <= 1'b1;
      host_addr <= a[core_pkg::MEM_AW-1:0];
      host_wdata <= d;
      do @(posedge clk); while (!host_gnt);
      host_req <= 1'b0;
      host_we <= 1'b0;
   endtask

   task automatic host_read(input int a, output logic [core_pkg::XLEN-1:0] d);
      @(posedge clk);
      host_req <= 1'b1;
      host_we <= 1'b0;
      host_addr <= a[core_pkg::MEM_AW-1:0];
      do @(posedge clk); while (!host_gnt);
      host_req <= 1'b0;
      @(negedge clk);
      d = host_rdata;                            // registered read.
   endtask

   task automatic check_word(input int addr, input logic [core_pkg::XLEN-1:0] got,
         input logic [core_pkg::XLEN-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t ns: o_host_rdata of word %0d is %h, expected %h",
                  $time, addr, got, exp);
      end
   endtask

   task automatic check_halt(input int r, input logic halted);
      checks++;
      if (halted !== 1'b1) begin
         errors++;
         $display("row %0d: the core never raised o_halt at the end of its program", r);
      end
   endtask

   task automatic run_row(input int r);
      logic [core_pkg::XLEN-1:0] got;
      int                        wait_cyc, errs_before;
      errs_before = errors;
      for (int k = 0; k < SLOTS / 2; k++) begin
         host_write(k, {prog[r][2 * k + 1], prog[r][2 * k]});
      end
      for (int k = 0; k < DW; k++) begin
         host_write(DBASE + k, pre[r][k]);
      end
      @(posedge clk);
      run <= 1'b1;
      wait_cyc = 0;
      do begin
         @(negedge clk);
         wait_cyc++;
      end while (!halt && wait_cyc < 12 * (n_insn[r] + 1));
      check_halt(r, halt);
      @(posedge clk);
      run <= 1'b0;                               // next run restarts at pc 0.
      for (int k = 0; k < DW; k++) begin
         host_read(DBASE + k, got);
         check_word(DBASE + k, got, expect_w[r][k]);
      end
      $display("row %0d: %0d instructions, %0d errors", r, n_insn[r], errors - errs_before);
   endtask

   initial begin
      cycles = 0;
      @(posedge clk);
      while (cycles < limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("Test failures found");
      $finish;
   end

   initial begin
      rst_n = 1'b0;
      run = 1'b0;
      host_req = 1'b0;
      host_we = 1'b0;
      host_addr = '0;
      host_wdata = '0;
      checks = 0;
      errors = 0;
      void'($urandom(32'h2cc6));
      build_table();
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      for (int r = 0; r < ROWS; r++) begin
         run_row(r);
      end
      $display("%0d rows, %0d checks, %0d errors", ROWS, checks, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// File: all.f
core_pkg.sv
idu.sv
ifu.sv
regfile.sv
exu.sv
lsu.sv
mem_arb.sv
unified_mem.sv
core_top.sv
tb_clk.sv
tb_top.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and search the log for the result
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timescale 1ns/1ps --top-module tb_top -f all.f -o tb_top_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_top_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
   exit 0
fi
exit 1
